/* hdl/cpu_pkg.sv */
/*
  cpu package
  word and index types, alu operation codes, the instruction word union
  and the encodings shared by the five-stage rv32i subset pipeline
*/
package cpu_pkg;

  typedef logic [31:0] word_t;     // data or address word
  typedef logic [4:0]  reg_idx_t;  // register index

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;  // bit 5 picks sub / sra
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm;  // sign extended by decode
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_hi;  // imm[11:5]
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;  // imm[4:0]
    logic [6:0] opcode;
  } s_view_t;

  // one instruction word seen through each format
  typedef union packed {
    r_view_t r;
    i_view_t i;
    s_view_t s;
  } inst_t;

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;  // ecall

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam reg_idx_t halt_reg  = 5'd17;          // a7 holds the call number
  localparam word_t    halt_code = 32'd10;         // exit call
  localparam word_t    nop_inst  = 32'h00000013;   // addi x0, x0, 0

endpackage

/* hdl/fetch_stage.sv */
/*
  fetch stage
  program counter and if/id instruction register, both held on stall
*/
`timescale 1ns/1ps

module fetch_stage (
  input  logic           clk,
  input  logic           reset,
  input  logic           stall,
  output cpu_pkg::word_t imem_addr,
  input  cpu_pkg::word_t imem_data,
  output cpu_pkg::inst_t if_inst
);
  import cpu_pkg::*;

  word_t pc;

  assign imem_addr = pc;  // memory answers in the same cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= '0;
      if_inst <= nop_inst;      // decode sees a harmless addi
    end else if (!stall) begin
      pc      <= pc + 32'd4;    // no redirects in this core
      if_inst <= imem_data;
    end
  end

endmodule

/* hdl/decode_stage.sv */
/*
  decode stage
  main control, immediate build, alu operation decode and ecall halt check
  loads the id/ex register, or a bubble while the hazard unit stalls
*/
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  cpu_pkg::inst_t    if_inst,
  output cpu_pkg::reg_idx_t rs1,
  output cpu_pkg::reg_idx_t rs2,
  input  cpu_pkg::word_t    rs1_data,
  input  cpu_pkg::word_t    rs2_data,
  output cpu_pkg::alu_op_t  ex_alu_op,
  output logic              ex_alu_src,
  output logic              ex_mem_read,
  output logic              ex_mem_write,
  output logic              ex_mem_to_reg,
  output logic              ex_reg_write,
  output cpu_pkg::reg_idx_t ex_rs1,
  output cpu_pkg::reg_idx_t ex_rs2,
  output cpu_pkg::reg_idx_t ex_rd,
  output cpu_pkg::word_t    ex_rs1_data,
  output cpu_pkg::word_t    ex_rs2_data,
  output cpu_pkg::word_t    ex_imm,
  output logic              ex_halt
);
  import cpu_pkg::*;

  logic    alu_src;
  logic    mem_read;
  logic    mem_write;
  logic    mem_to_reg;
  logic    reg_write;
  logic    is_ecall;
  logic    alt_bit;  // instruction bit 30
  alu_op_t alu_op;
  word_t   imm;

  always_comb begin
    alu_src    = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    reg_write  = 1'b0;
    is_ecall   = 1'b0;
    case (if_inst.r.opcode)
      op_reg: reg_write = 1'b1;
      op_imm: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      op_load: begin
        alu_src    = 1'b1;    // base plus offset
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        reg_write  = 1'b1;
      end
      op_store: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      op_system: is_ecall = 1'b1;
      default: ;              // unknown opcodes retire as nothing
    endcase
  end

  // s view splits the offset around rd
  assign imm = (if_inst.r.opcode == op_store) ?
               {{20{if_inst.s.imm_hi[6]}}, if_inst.s.imm_hi, if_inst.s.imm_lo} :
               {{20{if_inst.i.imm[11]}}, if_inst.i.imm};

  assign alt_bit = if_inst.r.funct7[5];

  always_comb begin
    alu_op = alu_add;         // loads and stores add the offset
    if (if_inst.r.opcode == op_reg || if_inst.r.opcode == op_imm) begin
      case (if_inst.r.funct3)
        f3_add_sub: alu_op = (if_inst.r.opcode == op_reg && alt_bit) ? alu_sub : alu_add;
        f3_sll:     alu_op = alu_sll;
        f3_slt:     alu_op = alu_slt;
        f3_xor:     alu_op = alu_xor;
        f3_srl_sra: alu_op = alt_bit ? alu_sra : alu_srl;  // same bit in both formats
        f3_or:      alu_op = alu_or;
        f3_and:     alu_op = alu_and;
        default:    alu_op = alu_add;
      endcase
    end
  end

  assign rs1 = is_ecall ? halt_reg : if_inst.r.rs1;  // ecall reads a7
  assign rs2 = if_inst.r.rs2;

  always_ff @(posedge clk) begin
    if (reset || stall) begin
      ex_alu_op     <= alu_add;  // bubble
      ex_alu_src    <= 1'b0;
      ex_mem_read   <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_mem_to_reg <= 1'b0;
      ex_reg_write  <= 1'b0;
      ex_halt       <= 1'b0;
    end else begin
      ex_alu_op     <= alu_op;
      ex_alu_src    <= alu_src;
      ex_mem_read   <= mem_read;
      ex_mem_write  <= mem_write;
      ex_mem_to_reg <= mem_to_reg;
      ex_reg_write  <= reg_write;
      ex_halt       <= is_ecall && (rs1_data == halt_code);
    end
    ex_rs1      <= rs1;
    ex_rs2      <= rs2;
    ex_rd       <= if_inst.r.rd;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
  end

endmodule

/* hdl/register_file.sv */
/*
  register file
  32 x 32-bit, two read ports, one write port from writeback
  a read of the register being written returns the new value
*/
`timescale 1ns/1ps

module register_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  output cpu_pkg::word_t    rs1_data,
  output cpu_pkg::word_t    rs2_data,
  input  logic              wb_valid,  // never set for x0
  input  cpu_pkg::reg_idx_t wb_rd,
  input  cpu_pkg::word_t    wb_data
);
  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;              // each program starts clean
      end
    end else if (wb_valid) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // x0 first, then same-cycle bypass
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

/* hdl/execute_stage.sv */
/*
  execute stage
  operand forwarding, immediate select, alu and the ex/mem register
*/
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::alu_op_t  ex_alu_op,
  input  logic              ex_alu_src,
  input  logic              ex_mem_read,
  input  logic              ex_mem_write,
  input  logic              ex_mem_to_reg,
  input  logic              ex_reg_write,
  input  cpu_pkg::reg_idx_t ex_rd,
  input  cpu_pkg::word_t    ex_rs1_data,
  input  cpu_pkg::word_t    ex_rs2_data,
  input  cpu_pkg::word_t    ex_imm,
  input  logic              ex_halt,
  input  logic [1:0]        fwd_a,
  input  logic [1:0]        fwd_b,
  input  cpu_pkg::word_t    wb_data,
  output cpu_pkg::word_t    mem_alu_out,
  output cpu_pkg::word_t    mem_store_data,
  output cpu_pkg::reg_idx_t mem_rd,
  output logic              mem_mem_read,
  output logic              mem_mem_write,
  output logic              mem_mem_to_reg,
  output logic              mem_reg_write,
  output logic              mem_halt
);
  import cpu_pkg::*;

  word_t op_a;
  word_t rs2_fwd;     // also the store data
  word_t op_b;
  word_t alu_result;

  function automatic word_t fwd_mux(logic [1:0] sel, word_t id_val);
    case (sel)
      2'b01:   return mem_alu_out;  // one ahead
      2'b10:   return wb_data;      // two ahead
      default: return id_val;
    endcase
  endfunction

  always_comb begin
    op_a    = fwd_mux(fwd_a, ex_rs1_data);
    rs2_fwd = fwd_mux(fwd_b, ex_rs2_data);
    op_b    = ex_alu_src ? ex_imm : rs2_fwd;
  end

  always_comb begin
    case (ex_alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_sll: alu_result = op_a << op_b[4:0];  // shamt in low five bits
      alu_srl: alu_result = op_a >> op_b[4:0];
      alu_sra: alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
      alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_mem_read   <= 1'b0;
      mem_mem_write  <= 1'b0;
      mem_mem_to_reg <= 1'b0;
      mem_reg_write  <= 1'b0;
      mem_halt       <= 1'b0;
    end else begin
      mem_mem_read   <= ex_mem_read;
      mem_mem_write  <= ex_mem_write;
      mem_mem_to_reg <= ex_mem_to_reg;
      mem_reg_write  <= ex_reg_write;
      mem_halt       <= ex_halt;
    end
    mem_alu_out    <= alu_result;  // result or address
    mem_store_data <= rs2_fwd;
    mem_rd         <= ex_rd;
  end

endmodule

/* hdl/memory_stage.sv */
/*
  memory stage
  word data memory, writeback select and the mem/wb register
*/
`timescale 1ns/1ps

module memory_stage #(
  parameter int dmem_words = 1024
) (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::word_t    mem_alu_out,
  input  cpu_pkg::word_t    mem_store_data,
  input  cpu_pkg::reg_idx_t mem_rd,
  input  logic              mem_mem_read,
  input  logic              mem_mem_write,
  input  logic              mem_mem_to_reg,
  input  logic              mem_reg_write,
  input  logic              mem_halt,
  output logic              wb_valid,
  output cpu_pkg::reg_idx_t wb_rd,
  output cpu_pkg::word_t    wb_data,
  output logic              wb_reg_write,
  output logic              is_halted
);
  import cpu_pkg::*;

  localparam int idx_bits = $clog2(dmem_words);

  word_t dmem [dmem_words];
  logic [idx_bits-1:0] word_idx;
  word_t load_data;

  assign word_idx  = mem_alu_out[idx_bits+1:2];  // byte offset ignored
  assign load_data = mem_mem_read ? dmem[word_idx] : '0;

  always_ff @(posedge clk) begin
    if (mem_mem_write) begin
      dmem[word_idx] <= mem_store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      is_halted    <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
      is_halted    <= mem_halt;       // ecall reaches writeback
    end
    wb_rd   <= mem_rd;
    wb_data <= mem_mem_to_reg ? load_data : mem_alu_out;
  end

  assign wb_valid = wb_reg_write && (wb_rd != '0);  // x0 writes are dropped

endmodule

/* hdl/hazard_unit.sv */
/*
  hazard unit
  forwarding selects for execute, stall for load-use and for an ecall
  whose a7 still has a writer in ex or mem
*/
`timescale 1ns/1ps

module hazard_unit (
  input  cpu_pkg::inst_t    if_inst,
  input  cpu_pkg::reg_idx_t ex_rs1,
  input  cpu_pkg::reg_idx_t ex_rs2,
  input  cpu_pkg::reg_idx_t ex_rd,
  input  logic              ex_mem_read,
  input  logic              ex_reg_write,
  input  cpu_pkg::reg_idx_t mem_rd,
  input  logic              mem_reg_write,
  input  cpu_pkg::reg_idx_t wb_rd,
  input  logic              wb_reg_write,
  output logic              stall,
  output logic [1:0]        fwd_a,
  output logic [1:0]        fwd_b
);
  import cpu_pkg::*;

  logic uses_rs1;
  logic uses_rs2;
  logic load_use;
  logic halt_wait;

  // ex/mem wins over mem/wb, x0 never forwarded
  function automatic logic [1:0] fwd_sel(reg_idx_t src);
    if (mem_reg_write && mem_rd != '0 && mem_rd == src) return 2'b01;
    if (wb_reg_write && wb_rd != '0 && wb_rd == src) return 2'b10;
    return 2'b00;
  endfunction

  always_comb begin
    fwd_a = fwd_sel(ex_rs1);
    fwd_b = fwd_sel(ex_rs2);
  end

  always_comb begin
    uses_rs2 = (if_inst.r.opcode == op_reg) || (if_inst.r.opcode == op_store);
    uses_rs1 = uses_rs2 || (if_inst.r.opcode == op_imm) || (if_inst.r.opcode == op_load);
    load_use = ex_mem_read && (ex_rd != '0) &&
               ((uses_rs1 && ex_rd == if_inst.r.rs1) || (uses_rs2 && ex_rd == if_inst.r.rs2));
    // halt is decided from the register file read
    halt_wait = (if_inst.r.opcode == op_system) &&
                ((ex_reg_write && ex_rd == halt_reg) || (mem_reg_write && mem_rd == halt_reg));
    stall = load_use || halt_wait;
  end

endmodule

/* hdl/pipelined_cpu.sv */
/*
  pipelined cpu top
  five-stage rv32i subset core with forwarding, load-use stall and ecall halt
  instruction memory sits outside, results leave on the writeback trace
*/
`timescale 1ns/1ps

module pipelined_cpu #(
  parameter int dmem_words = 1024  // data memory depth in words
) (
  input  logic              clk,
  input  logic              reset,
  output cpu_pkg::word_t    imem_addr,
  input  cpu_pkg::word_t    imem_data,
  output logic              wb_valid,
  output cpu_pkg::reg_idx_t wb_rd,
  output cpu_pkg::word_t    wb_data,
  output logic              is_halted
);
  import cpu_pkg::*;

  inst_t    if_inst;       // if/id instruction
  logic     stall;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;

  alu_op_t  ex_alu_op;     // id/ex fields
  logic     ex_alu_src;
  logic     ex_mem_read;
  logic     ex_mem_write;
  logic     ex_mem_to_reg;
  logic     ex_reg_write;
  logic     ex_halt;
  reg_idx_t ex_rs1;
  reg_idx_t ex_rs2;
  reg_idx_t ex_rd;
  word_t    ex_rs1_data;
  word_t    ex_rs2_data;
  word_t    ex_imm;
  logic [1:0] fwd_a;
  logic [1:0] fwd_b;

  word_t    mem_alu_out;   // ex/mem fields
  word_t    mem_store_data;
  reg_idx_t mem_rd;
  logic     mem_mem_read;
  logic     mem_mem_write;
  logic     mem_mem_to_reg;
  logic     mem_reg_write;
  logic     mem_halt;
  logic     wb_reg_write;  // mem/wb write enable, x0 included

  fetch_stage u_fetch (
    .clk, .reset, .stall, .imem_addr, .imem_data, .if_inst
  );

  decode_stage u_decode (
    .clk, .reset, .stall, .if_inst, .rs1, .rs2, .rs1_data, .rs2_data,
    .ex_alu_op, .ex_alu_src, .ex_mem_read, .ex_mem_write, .ex_mem_to_reg,
    .ex_reg_write, .ex_rs1, .ex_rs2, .ex_rd, .ex_rs1_data, .ex_rs2_data,
    .ex_imm, .ex_halt
  );

  register_file u_regs (
    .clk, .reset, .rs1, .rs2, .rs1_data, .rs2_data, .wb_valid, .wb_rd, .wb_data
  );

  execute_stage u_execute (
    .clk, .reset, .ex_alu_op, .ex_alu_src, .ex_mem_read, .ex_mem_write,
    .ex_mem_to_reg, .ex_reg_write, .ex_rd, .ex_rs1_data, .ex_rs2_data,
    .ex_imm, .ex_halt, .fwd_a, .fwd_b, .wb_data, .mem_alu_out,
    .mem_store_data, .mem_rd, .mem_mem_read, .mem_mem_write,
    .mem_mem_to_reg, .mem_reg_write, .mem_halt
  );

  memory_stage #(
    .dmem_words(dmem_words)
  ) u_memory (
    .clk, .reset, .mem_alu_out, .mem_store_data, .mem_rd, .mem_mem_read,
    .mem_mem_write, .mem_mem_to_reg, .mem_reg_write, .mem_halt,
    .wb_valid, .wb_rd, .wb_data, .wb_reg_write, .is_halted
  );

  hazard_unit u_hazard (
    .if_inst, .ex_rs1, .ex_rs2, .ex_rd, .ex_mem_read, .ex_reg_write,
    .mem_rd, .mem_reg_write, .wb_rd, .wb_reg_write, .stall, .fwd_a, .fwd_b
  );

endmodule

/* include/cpu_test_programs.svh */
/*
  cpu test programs
  instruction words and expected retirements for each test program
  expected entries pack the destination register above the value
*/
`ifndef CPU_TEST_PROGRAMS_SVH
`define CPU_TEST_PROGRAMS_SVH

localparam int num_progs  = 4;
localparam int prog_slots = 16;

localparam logic [31:0] prog_inst [num_progs][prog_slots] = '{
  '{32'h00C00093, 32'hFFD00113, 32'h0F006193, 32'h00102213,   // independent alu ops
    32'h002082B3, 32'h40208333, 32'h004093B3, 32'h00415433,
    32'h404154B3, 32'h00112533, 32'h0030C5B3, 32'h00317633,
    32'h0040E6B3, 32'h00A00893, 32'h00000073, 32'h00000013},
  '{32'h00000093, 32'h00000113, 32'h002081B3, 32'h00118233,   // addi immediates set at run time
    32'h403202B3, 32'h00A00893, 32'h00000073, 32'h00000013,
    32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013,
    32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
  '{32'h04000093, 32'h12300113, 32'h0020A223, 32'h0040A183,   // store, load, load-use
    32'h00318233, 32'h0040A283, 32'h00128313, 32'h00A00893,
    32'h00000073, 32'h00000013, 32'h00000013, 32'h00000013,
    32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
  '{32'h03700013, 32'hFF000093, 32'h00108033, 32'h00100133,   // x0 writes and shift immediates
    32'h00209193, 32'h0040D213, 32'h4040D293, 32'h0FF1F313,
    32'hFFF34393, 32'h00A00893, 32'h00000073, 32'h00000013,
    32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013}
};

localparam logic [39:0] prog_exp [num_progs][prog_slots] = '{
  '{40'h01_0000000C, 40'h02_FFFFFFFD, 40'h03_000000F0, 40'h04_00000001,
    40'h05_00000009, 40'h06_0000000F, 40'h07_00000018, 40'h08_7FFFFFFE,
    40'h09_FFFFFFFE, 40'h0A_00000001, 40'h0B_000000FC, 40'h0C_000000F0,
    40'h0D_0000000D, 40'h11_0000000A, 40'h0, 40'h0},
  '{40'h01_00000000, 40'h02_00000000, 40'h03_00000000, 40'h04_00000000,  // values from immediates
    40'h05_00000000, 40'h11_0000000A, 40'h0, 40'h0,
    40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0},
  '{40'h01_00000040, 40'h02_00000123, 40'h03_00000123, 40'h04_00000246,
    40'h05_00000123, 40'h06_00000124, 40'h11_0000000A, 40'h0,
    40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0},
  '{40'h01_FFFFFFF0, 40'h02_FFFFFFF0, 40'h03_FFFFFFC0, 40'h04_0FFFFFFF,
    40'h05_FFFFFFFF, 40'h06_000000C0, 40'h07_FFFFFF3F, 40'h11_0000000A,
    40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0, 40'h0}
};

localparam int prog_ret_count [num_progs] = '{14, 6, 7, 8};  // writing instructions

`endif

/* test/tb_pipelined_cpu.sv */
/*
  pipelined cpu testbench
  runs each program of the table against an instruction memory model,
  compares every writeback retirement in order and waits for the halt
*/
`timescale 1ns/1ps

module tb_pipelined_cpu;
  import cpu_pkg::*;

  `include "cpu_test_programs.svh"

  localparam int          cycles_per_prog = 40;                       // timeout margin per program
  localparam int          timeout_cycles  = num_progs * cycles_per_prog;
  localparam int unsigned seed            = 32'h3cc9;

  logic  clk;
  logic  reset;
  word_t imem_addr;
  word_t imem_data;
  logic  wb_valid;
  reg_idx_t wb_rd;
  word_t wb_data;
  logic  is_halted;

  logic [31:0] cur_prog [prog_slots];  // program seen by the imem model
  logic [39:0] cur_exp [prog_slots];   // rd above value
  int          exp_count;
  int          error_count;
  int          cycle_count;
  logic [11:0] imm_a;                  // random immediates of test 1
  logic [11:0] imm_b;
  string       test_names [num_progs] = '{"alu ops", "forwarding", "load store", "x0 and shifts"};

  pipelined_cpu DUT (
    .clk, .reset, .imem_addr, .imem_data, .wb_valid, .wb_rd, .wb_data, .is_halted
  );

  // past the last slot the core only sees nops
  assign imem_data = (imem_addr[31:6] == '0) ? cur_prog[imem_addr[5:2]] : 32'h00000013;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the core did not halt within %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] encode_addi(logic [4:0] rd, logic [11:0] imm);
    return {imm, 5'd0, 3'b000, rd, 7'b0010011};  // addi rd, x0, imm
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic load_program(input int t);
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < prog_slots; i++) begin
      cur_prog[i] <= prog_inst[t][i];
      cur_exp[i] = prog_exp[t][i];
    end
    exp_count = prog_ret_count[t];
    if (t == 1) begin                                  // immediates drawn at run time
      a = {{20{imm_a[11]}}, imm_a};
      b = {{20{imm_b[11]}}, imm_b};
      cur_prog[0] <= encode_addi(5'd1, imm_a);
      cur_prog[1] <= encode_addi(5'd2, imm_b);
      cur_exp[0] = {8'd1, a};
      cur_exp[1] = {8'd2, b};
      cur_exp[2] = {8'd3, a + b};                      // add x3, x1, x2
      cur_exp[3] = {8'd4, a + b + a};                  // add x4, x3, x1
      cur_exp[4] = {8'd5, a};                          // sub x5, x4, x3
    end
  endtask

  task automatic run_program(input int t);
    int ret_idx;
    int errs_before;
    bit halted;
    ret_idx     = 0;
    halted      = 1'b0;
    errs_before = error_count;
    @(posedge clk);
    reset <= 1'b1;
    load_program(t);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    while (!halted) begin
      @(negedge clk);                                  // outputs settled mid cycle
      if (is_halted) begin
        halted = 1'b1;
        check_value("retire_count", ret_idx, exp_count);  // counted before this cycle
      end
      if (wb_valid) begin
        if (ret_idx < exp_count) begin
          check_value("wb_rd", {27'd0, wb_rd}, {27'd0, cur_exp[ret_idx][36:32]});
          check_value("wb_data", wb_data, cur_exp[ret_idx][31:0]);
        end else begin
          $display("test %0d: extra retirement to x%0d beyond the expected sequence", t, wb_rd);
          error_count++;
        end
        ret_idx++;
      end
    end
    if (error_count == errs_before)
      $display("test %0d (%s): %0d retirements ok", t, test_names[t], ret_idx);
    else
      $display("test %0d (%s): %0d errors", t, test_names[t], error_count - errs_before);
  endtask

  initial begin
    int unsigned rnd;
    int bad_tests;
    int errs_before;
    reset       <= 1'b1;
    error_count = 0;
    bad_tests   = 0;
    exp_count   = 0;
    for (int i = 0; i < prog_slots; i++) begin
      cur_prog[i] <= 32'h00000013;
      cur_exp[i]  = '0;
    end
    rnd   = $urandom(seed);                            // seed once
    rnd   = $urandom();
    imm_a = rnd[11:0];
    rnd   = $urandom();
    imm_b = rnd[11:0];
    for (int t = 0; t < num_progs; t++) begin
      errs_before = error_count;
      run_program(t);
      if (error_count != errs_before)
        bad_tests++;
    end
    $display("tests %0d, clean %0d, with errors %0d, total errors %0d",
             num_progs, num_progs - bad_tests, bad_tests, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+include
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/pipelined_cpu.sv
test/tb_pipelined_cpu.sv

/* run.sh */
#!/bin/sh
# build and run the pipelined cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_pipelined_cpu

./obj_dir/Vtb_pipelined_cpu > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"
